// File: verilog/issue_pkg.sv
/* issue cluster shared definitions
   widths, vector types, opcode encoding and the memory-op test */
package issue_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// slot count, the swap network is fixed at four
	localparam int lanes = 4;
	localparam int reg_w = 4;
	localparam int data_w = 8;
	localparam int imm_w = 5;
	localparam int op_w = 4;

	typedef logic [reg_w-1:0] reg_idx_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [imm_w-1:0] imm_t;

	//////////////////////////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [op_w-1:0]
	{
		op_nop = 4'd0,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		// shift amount from low 3 bits of source 2
		op_shl,
		op_shr,
		// source 1 plus zero-extended immediate
		op_addi,
		op_load,
		op_store
	} op_t;

	// load or store, both need the single memory port
	function automatic logic is_mem(op_t op);
		return (op == op_load) || (op == op_store);
	endfunction

endpackage

// File: verilog/bundle_sort.sv
/* bundle sort stage
   registers the incoming bundle and flags the memory op that must move to slot 4 */
`timescale 1ns/1ps

module bundle_sort
(
	input	logic						clk,
	input	logic						rst,

	input	logic		[issue_pkg::lanes:1]		in_vld,
	input	issue_pkg::op_t		[issue_pkg::lanes:1]	in_op,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_des,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s1,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s2,
	input	issue_pkg::imm_t	[issue_pkg::lanes:1]	in_ime,

	output	logic		[issue_pkg::lanes:1]		q_vld,
	output	issue_pkg::op_t		[issue_pkg::lanes:1]	q_op,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	q_des,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	q_s1,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	q_s2,
	output	issue_pkg::imm_t	[issue_pkg::lanes:1]	q_ime,
	output	logic		[issue_pkg::lanes:1]		swap_flags,
	output	logic						reject
);

	// valid memory ops per slot
	logic	[issue_pkg::lanes:1]	mem_hit;
	logic	[2:0]			mem_cnt;
	logic	[issue_pkg::lanes:1]	flags_d;
	logic				reject_d;

	always_comb
	begin
		mem_cnt = '0;
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			mem_hit[k] = in_vld[k] && issue_pkg::is_mem(in_op[k]);
			mem_cnt = mem_cnt + 3'(mem_hit[k]);
		end
		// more than one memory op cannot share the port
		reject_d = (mem_cnt > 3'd1);
		// exchange only when the lone memory op sits below slot 4
		if ((mem_cnt == 3'd1) && !mem_hit[issue_pkg::lanes])
			flags_d = mem_hit | {1'b1, {(issue_pkg::lanes-1){1'b0}}};
		else
			flags_d = '0;
	end

	// control part of the bundle register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			q_vld <= '0;
			swap_flags <= '0;
			reject <= 1'b0;
		end
		else
		begin
			// rejected bundle goes down as all-invalid
			q_vld <= reject_d ? '0 : in_vld;
			swap_flags <= flags_d;
			reject <= reject_d;
		end
	end

	// instruction fields
	always_ff @(posedge clk)
	begin
		q_op <= in_op;
		q_des <= in_des;
		q_s1 <= in_s1;
		q_s2 <= in_s2;
		q_ime <= in_ime;
	end

	// either no exchange or a pair that includes slot 4
	assert property (@(posedge clk) disable iff (rst)
		(swap_flags == '0) ||
		(swap_flags[issue_pkg::lanes] && ($countones(swap_flags) == 2)))
		else $error("bad swap flags %b", swap_flags);

endmodule

// File: verilog/ins_swap.sv
/* swap network
   moves the bundle's memory instruction into slot 4 */
`timescale 1ns/1ps

module ins_swap
(
	input	logic						clk,
	input	logic						rst,
	input	logic		[issue_pkg::lanes:1]		swap_flags,

	input	logic		[issue_pkg::lanes:1]		in_vld,
	input	issue_pkg::op_t		[issue_pkg::lanes:1]	in_op,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_des,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s1,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s2,
	input	issue_pkg::imm_t	[issue_pkg::lanes:1]	in_ime,

	output	logic		[issue_pkg::lanes:1]		out_vld,
	output	issue_pkg::op_t		[issue_pkg::lanes:1]	out_op,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	out_des,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	out_s1,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	out_s2,
	output	issue_pkg::imm_t	[issue_pkg::lanes:1]	out_ime
);

	// source slot for each output slot
	logic	[2:0]	src [issue_pkg::lanes:1];
	// memory ops left in slots 1 to 3
	logic	[issue_pkg::lanes-1:1]	low_mem;

	always_comb
	begin
		for (int k = 1; k <= issue_pkg::lanes; k++)
			src[k] = 3'(k);
		case (swap_flags)
			4'b1001:
			begin
				src[1] = 3'd4;
				src[4] = 3'd1;
			end
			4'b1010:
			begin
				src[2] = 3'd4;
				src[4] = 3'd2;
			end
			4'b1100:
			begin
				src[3] = 3'd4;
				src[4] = 3'd3;
			end
			// identity pattern
			default:
			begin
			end
		endcase
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			out_vld[k] = in_vld[src[k]];
			out_op[k] = in_op[src[k]];
			out_des[k] = in_des[src[k]];
			out_s1[k] = in_s1[src[k]];
			out_s2[k] = in_s2[src[k]];
			out_ime[k] = in_ime[src[k]];
		end
		for (int k = 1; k < issue_pkg::lanes; k++)
			low_mem[k] = out_vld[k] && issue_pkg::is_mem(out_op[k]);
	end

	// sort flags and swap together keep the memory op off slots 1 to 3
	assert property (@(posedge clk) disable iff (rst) low_mem == '0)
		else $error("memory op left below slot 4");

endmodule

// File: verilog/exec_lane.sv
/* execution lane
   ALU and memory address generation with a registered result */
`timescale 1ns/1ps

module exec_lane
(
	input	logic			clk,
	input	logic			rst,

	input	logic			vld,
	input	issue_pkg::op_t		op,
	input	issue_pkg::reg_idx_t	des,
	input	issue_pkg::reg_idx_t	s1,
	input	issue_pkg::reg_idx_t	s2,
	input	issue_pkg::imm_t	ime,
	input	issue_pkg::data_t	rd1,
	input	issue_pkg::data_t	rd2,

	output	issue_pkg::reg_idx_t	ra1,
	output	issue_pkg::reg_idx_t	ra2,
	output	logic			r_vld,
	output	logic			r_wen,
	output	issue_pkg::reg_idx_t	r_des,
	output	issue_pkg::data_t	r_data,
	output	issue_pkg::data_t	r_maddr,
	output	logic			r_mem_ld,
	output	logic			r_mem_st,
	output	issue_pkg::data_t	r_sdata
);

	issue_pkg::data_t	ime_ext;
	issue_pkg::data_t	alu;

	// register file read addresses straight from the sources
	assign ra1 = s1;
	assign ra2 = s2;
	assign ime_ext = issue_pkg::data_t'(ime);

	always_comb
	begin
		case (op)
			issue_pkg::op_add:	alu = rd1 + rd2;
			issue_pkg::op_sub:	alu = rd1 - rd2;
			issue_pkg::op_and:	alu = rd1 & rd2;
			issue_pkg::op_or:	alu = rd1 | rd2;
			issue_pkg::op_xor:	alu = rd1 ^ rd2;
			issue_pkg::op_shl:	alu = rd1 << rd2[2:0];
			issue_pkg::op_shr:	alu = rd1 >> rd2[2:0];
			// addi, load and store share the adder
			default:		alu = rd1 + ime_ext;
		endcase
	end

	// control bits
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			r_vld <= 1'b0;
			r_wen <= 1'b0;
			r_mem_ld <= 1'b0;
			r_mem_st <= 1'b0;
		end
		else
		begin
			r_vld <= vld;
			// nop and store leave the registers alone
			r_wen <= vld && (op != issue_pkg::op_nop) && (op != issue_pkg::op_store);
			r_mem_ld <= vld && (op == issue_pkg::op_load);
			r_mem_st <= vld && (op == issue_pkg::op_store);
		end
	end

	// result payload
	always_ff @(posedge clk)
	begin
		r_des <= des;
		r_data <= alu;
		r_maddr <= rd1 + ime_ext;
		r_sdata <= rd2;
	end

endmodule

// File: verilog/reg_file.sv
/* shared register file
   eight read ports, four write ports, higher slot wins, reads see same-cycle writes */
`timescale 1ns/1ps

module reg_file
#(
	parameter int NREGS = 16
)
(
	input	logic						clk,
	input	logic						rst,

	// read ports 2k-1 and 2k belong to lane k
	input	issue_pkg::reg_idx_t	[2*issue_pkg::lanes:1]	ra,
	output	issue_pkg::data_t	[2*issue_pkg::lanes:1]	rd,

	input	logic		[issue_pkg::lanes:1]		we,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	wa,
	input	issue_pkg::data_t	[issue_pkg::lanes:1]	wd
);

	issue_pkg::data_t	regs [NREGS];

	//////////////////////////////////////////////////////////////////////
	// write, slot order so the last slot sticks
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			for (int k = 1; k <= issue_pkg::lanes; k++)
				if (we[k])
					regs[wa[k]] <= wd[k];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read with write-first bypass
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int p = 1; p <= 2*issue_pkg::lanes; p++)
		begin
			rd[p] = regs[ra[p]];
			// later slots override, same priority as the write
			for (int k = 1; k <= issue_pkg::lanes; k++)
				if (we[k] && (wa[k] == ra[p]))
					rd[p] = wd[k];
		end
	end

endmodule

// File: verilog/retire_mem.sv
/* retire stage
   data memory access for slot 4, register writeback and registered retire outputs */
`timescale 1ns/1ps

module retire_mem
#(
	parameter int MEM_WORDS = 16
)
(
	input	logic						clk,
	input	logic						rst,
	// reject flag as it leaves the sort register
	input	logic						reject,

	input	logic		[issue_pkg::lanes:1]		r_vld,
	input	logic		[issue_pkg::lanes:1]		r_wen,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	r_des,
	input	issue_pkg::data_t	[issue_pkg::lanes:1]	r_data,
	input	logic		[issue_pkg::lanes:1]		r_mem_ld,
	input	logic		[issue_pkg::lanes:1]		r_mem_st,
	// slot 4 memory fields
	input	issue_pkg::data_t				r_maddr,
	input	issue_pkg::data_t				r_sdata,

	output	logic		[issue_pkg::lanes:1]		we,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	wa,
	output	issue_pkg::data_t	[issue_pkg::lanes:1]	wd,

	output	logic		[issue_pkg::lanes:1]		ret_vld,
	output	logic		[issue_pkg::lanes:1]		ret_wen,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	ret_des,
	output	issue_pkg::data_t	[issue_pkg::lanes:1]	ret_data,
	output	logic						ret_reject,
	output	logic						mem_we,
	output	logic		[$clog2(MEM_WORDS)-1:0]		mem_addr,
	output	issue_pkg::data_t				mem_wdata
);

	localparam int aw = $clog2(MEM_WORDS);

	issue_pkg::data_t	mem [MEM_WORDS];
	logic	[aw-1:0]	maddr;
	logic			st_en;
	// reject aligned with the lane registers
	logic			rej_q;

	assign maddr = r_maddr[aw-1:0];
	assign st_en = r_mem_st[issue_pkg::lanes];

	// writeback, load data replaces the slot 4 result
	always_comb
	begin
		we = r_wen;
		wa = r_des;
		wd = r_data;
		if (r_mem_ld[issue_pkg::lanes])
			wd[issue_pkg::lanes] = mem[maddr];
	end

	// data memory, one port behind slot 4
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (st_en)
			mem[maddr] <= r_sdata;
	end

	//////////////////////////////////////////////////////////////////////
	// retire registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rej_q <= 1'b0;
			ret_reject <= 1'b0;
			ret_vld <= '0;
			ret_wen <= '0;
			mem_we <= 1'b0;
		end
		else
		begin
			rej_q <= reject;
			ret_reject <= rej_q;
			ret_vld <= r_vld;
			ret_wen <= r_wen;
			mem_we <= st_en;
		end
	end

	always_ff @(posedge clk)
	begin
		ret_des <= wa;
		ret_data <= wd;
		mem_addr <= maddr;
		mem_wdata <= r_sdata;
	end

	// only slot 4 may carry a memory access after the swap
	assert property (@(posedge clk) disable iff (rst)
		(r_mem_ld[issue_pkg::lanes-1:1] | r_mem_st[issue_pkg::lanes-1:1]) == '0)
		else $error("memory op retiring outside slot 4");

endmodule

// File: verilog/issue_cluster.sv
/* issue and execute cluster top
   sort, swap, four execution lanes, shared register file and retire */
`timescale 1ns/1ps

module issue_cluster
#(
	parameter int NREGS = 16,
	parameter int MEM_WORDS = 16
)
(
	input	logic						clk,
	input	logic						rst,

	input	logic		[issue_pkg::lanes:1]		in_vld,
	input	issue_pkg::op_t		[issue_pkg::lanes:1]	in_op,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_des,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s1,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s2,
	input	issue_pkg::imm_t	[issue_pkg::lanes:1]	in_ime,

	output	logic		[issue_pkg::lanes:1]		ret_vld,
	output	logic		[issue_pkg::lanes:1]		ret_wen,
	output	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	ret_des,
	output	issue_pkg::data_t	[issue_pkg::lanes:1]	ret_data,
	output	logic						ret_reject,
	output	logic						mem_we,
	output	logic		[$clog2(MEM_WORDS)-1:0]		mem_addr,
	output	issue_pkg::data_t				mem_wdata
);

	//////////////////////////////////////////////////////////////////////
	// wires
	//////////////////////////////////////////////////////////////////////

	// sort register outputs
	logic		[issue_pkg::lanes:1]		q_vld;
	issue_pkg::op_t		[issue_pkg::lanes:1]	q_op;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	q_des, q_s1, q_s2;
	issue_pkg::imm_t	[issue_pkg::lanes:1]	q_ime;
	logic		[issue_pkg::lanes:1]		swap_flags;
	logic						reject;

	// after the swap
	logic		[issue_pkg::lanes:1]		sw_vld;
	issue_pkg::op_t		[issue_pkg::lanes:1]	sw_op;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	sw_des, sw_s1, sw_s2;
	issue_pkg::imm_t	[issue_pkg::lanes:1]	sw_ime;

	// register file ports
	issue_pkg::reg_idx_t	[2*issue_pkg::lanes:1]	ra;
	issue_pkg::data_t	[2*issue_pkg::lanes:1]	rd;
	logic		[issue_pkg::lanes:1]		we;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	wa;
	issue_pkg::data_t	[issue_pkg::lanes:1]	wd;

	// lane result registers
	logic		[issue_pkg::lanes:1]		l_vld, l_wen, l_mem_ld, l_mem_st;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	l_des;
	issue_pkg::data_t	[issue_pkg::lanes:1]	l_data, l_maddr, l_sdata;

	//////////////////////////////////////////////////////////////////////
	// instances
	//////////////////////////////////////////////////////////////////////

	bundle_sort u_sort (
		.clk(clk), .rst(rst),
		.in_vld(in_vld), .in_op(in_op), .in_des(in_des),
		.in_s1(in_s1), .in_s2(in_s2), .in_ime(in_ime),
		.q_vld(q_vld), .q_op(q_op), .q_des(q_des),
		.q_s1(q_s1), .q_s2(q_s2), .q_ime(q_ime),
		.swap_flags(swap_flags), .reject(reject)
	);

	ins_swap u_swap (
		.clk(clk), .rst(rst), .swap_flags(swap_flags),
		.in_vld(q_vld), .in_op(q_op), .in_des(q_des),
		.in_s1(q_s1), .in_s2(q_s2), .in_ime(q_ime),
		.out_vld(sw_vld), .out_op(sw_op), .out_des(sw_des),
		.out_s1(sw_s1), .out_s2(sw_s2), .out_ime(sw_ime)
	);

	// one lane per slot, lane k owns read ports 2k-1 and 2k
	for (genvar k = 1; k <= issue_pkg::lanes; k++)
	begin : g_lane
		exec_lane u_lane (
			.clk(clk), .rst(rst),
			.vld(sw_vld[k]), .op(sw_op[k]), .des(sw_des[k]),
			.s1(sw_s1[k]), .s2(sw_s2[k]), .ime(sw_ime[k]),
			.rd1(rd[2*k-1]), .rd2(rd[2*k]),
			.ra1(ra[2*k-1]), .ra2(ra[2*k]),
			.r_vld(l_vld[k]), .r_wen(l_wen[k]), .r_des(l_des[k]),
			.r_data(l_data[k]), .r_maddr(l_maddr[k]),
			.r_mem_ld(l_mem_ld[k]), .r_mem_st(l_mem_st[k]),
			.r_sdata(l_sdata[k])
		);
	end

	reg_file #(.NREGS(NREGS)) u_rf (
		.clk(clk), .rst(rst),
		.ra(ra), .rd(rd),
		.we(we), .wa(wa), .wd(wd)
	);

	retire_mem #(.MEM_WORDS(MEM_WORDS)) u_retire (
		.clk(clk), .rst(rst), .reject(reject),
		.r_vld(l_vld), .r_wen(l_wen), .r_des(l_des), .r_data(l_data),
		.r_mem_ld(l_mem_ld), .r_mem_st(l_mem_st),
		.r_maddr(l_maddr[issue_pkg::lanes]), .r_sdata(l_sdata[issue_pkg::lanes]),
		.we(we), .wa(wa), .wd(wd),
		.ret_vld(ret_vld), .ret_wen(ret_wen), .ret_des(ret_des),
		.ret_data(ret_data), .ret_reject(ret_reject),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule

// File: sim/issue_checker.sv
/* issue cluster checker
   reference model of sort, swap, register file and memory, scores the retire outputs */
`timescale 1ns/1ps

module issue_checker
#(
	parameter int NREGS = 16,
	parameter int MEM_WORDS = 16
)
(
	input	logic						clk,
	input	logic						rst,

	input	logic		[issue_pkg::lanes:1]		in_vld,
	input	issue_pkg::op_t		[issue_pkg::lanes:1]	in_op,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_des,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s1,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_s2,
	input	issue_pkg::imm_t	[issue_pkg::lanes:1]	in_ime,

	input	logic		[issue_pkg::lanes:1]		ret_vld,
	input	logic		[issue_pkg::lanes:1]		ret_wen,
	input	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	ret_des,
	input	issue_pkg::data_t	[issue_pkg::lanes:1]	ret_data,
	input	logic						ret_reject,
	input	logic						mem_we,
	input	logic		[$clog2(MEM_WORDS)-1:0]		mem_addr,
	input	issue_pkg::data_t				mem_wdata,

	output	int						pending,
	output	int						errors,
	output	int						checks
);

	localparam int aw = $clog2(MEM_WORDS);

	// model state
	issue_pkg::data_t	m_regs [NREGS];
	issue_pkg::data_t	m_mem [MEM_WORDS];
	// clock edges since reset
	int			edge_cnt;

	// expected retire values, one entry per bundle with a valid slot
	int						e_edge [$];
	logic		[issue_pkg::lanes:1]		e_vld [$];
	logic		[issue_pkg::lanes:1]		e_wen [$];
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	e_des [$];
	issue_pkg::data_t	[issue_pkg::lanes:1]	e_data [$];
	logic						e_rej [$];
	logic						e_mwe [$];
	logic		[aw-1:0]			e_maddr [$];
	issue_pkg::data_t				e_mwd [$];

	initial
	begin
		pending = 0;
		errors = 0;
		checks = 0;
		edge_cnt = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic issue_pkg::data_t alu_result(issue_pkg::op_t op,
		issue_pkg::data_t a, issue_pkg::data_t b, issue_pkg::imm_t ime);
		case (op)
			issue_pkg::op_add:	return a + b;
			issue_pkg::op_sub:	return a - b;
			issue_pkg::op_and:	return a & b;
			issue_pkg::op_or:	return a | b;
			issue_pkg::op_xor:	return a ^ b;
			// shift by low 3 bits of source 2
			issue_pkg::op_shl:	return a << b[2:0];
			issue_pkg::op_shr:	return a >> b[2:0];
			issue_pkg::op_addi:	return a + {3'b000, ime};
			default:		return '0;
		endcase
	endfunction

	task automatic clear_state();
		for (int i = 0; i < NREGS; i++)
			m_regs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			m_mem[i] = '0;
		e_edge.delete();
		e_vld.delete();
		e_wen.delete();
		e_des.delete();
		e_data.delete();
		e_rej.delete();
		e_mwe.delete();
		e_maddr.delete();
		e_mwd.delete();
		edge_cnt = 0;
		pending = 0;
	endtask

	task automatic apply_bundle();
		int					nmem;
		int					mslot;
		int					s;
		int					src [issue_pkg::lanes:1];
		logic					rej;
		logic		[issue_pkg::lanes:1]	v;
		logic		[issue_pkg::lanes:1]	w;
		issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	d;
		issue_pkg::data_t	[issue_pkg::lanes:1]	res;
		issue_pkg::data_t			a;
		issue_pkg::data_t			b;
		issue_pkg::data_t			addr8;
		logic					mwe;
		logic		[aw-1:0]		maddr;
		issue_pkg::data_t			mwd;
		nmem = 0;
		mslot = 0;
		mwe = 1'b0;
		maddr = '0;
		mwd = '0;
		// count valid loads and stores
		for (int k = 1; k <= issue_pkg::lanes; k++)
			if (in_vld[k] && ((in_op[k] == issue_pkg::op_load) ||
				(in_op[k] == issue_pkg::op_store)))
			begin
				nmem++;
				mslot = k;
			end
		rej = (nmem > 1);
		// lone memory op trades places with slot 4
		for (int k = 1; k <= issue_pkg::lanes; k++)
			src[k] = k;
		if ((nmem == 1) && (mslot != issue_pkg::lanes))
		begin
			src[mslot] = issue_pkg::lanes;
			src[issue_pkg::lanes] = mslot;
		end
		// all slots read the state from before the bundle
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			s = src[k];
			a = m_regs[in_s1[s]];
			b = m_regs[in_s2[s]];
			addr8 = a + {3'b000, in_ime[s]};
			v[k] = in_vld[s] && !rej;
			w[k] = v[k] && (in_op[s] != issue_pkg::op_nop) &&
				(in_op[s] != issue_pkg::op_store);
			d[k] = in_des[s];
			if (in_op[s] == issue_pkg::op_load)
				res[k] = m_mem[addr8[aw-1:0]];
			else
				res[k] = alu_result(in_op[s], a, b, in_ime[s]);
			if (v[k] && (in_op[s] == issue_pkg::op_store))
			begin
				mwe = 1'b1;
				maddr = addr8[aw-1:0];
				mwd = b;
			end
		end
		// highest slot writes last and wins
		for (int k = 1; k <= issue_pkg::lanes; k++)
			if (w[k])
				m_regs[d[k]] = res[k];
		if (mwe)
			m_mem[maddr] = mwd;
		e_edge.push_back(edge_cnt);
		e_vld.push_back(v);
		e_wen.push_back(w);
		e_des.push_back(d);
		e_data.push_back(res);
		e_rej.push_back(rej);
		e_mwe.push_back(mwe);
		e_maddr.push_back(maddr);
		e_mwd.push_back(mwd);
		pending = e_edge.size();
	endtask

	//////////////////////////////////////////////////////////////////////
	// scoring
	//////////////////////////////////////////////////////////////////////

	task automatic compare_val(input string name, input int idx,
		input logic [7:0] got, input logic [7:0] exp);
		string	label;
		label = (idx == 0) ? name : $sformatf("%s[%0d]", name, idx);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %0h expected %0h", $time, label, got, exp);
		end
	endtask

	// nothing due, pipeline output must be quiet
	task automatic expect_quiet();
		compare_val("ret_vld", 0, 8'(ret_vld), 8'h00);
		compare_val("ret_wen", 0, 8'(ret_wen), 8'h00);
		compare_val("ret_reject", 0, 8'(ret_reject), 8'h00);
		compare_val("mem_we", 0, 8'(mem_we), 8'h00);
	endtask

	task automatic score_retire();
		compare_val("ret_reject", 0, 8'(ret_reject), 8'(e_rej[0]));
		compare_val("mem_we", 0, 8'(mem_we), 8'(e_mwe[0]));
		if (e_mwe[0])
		begin
			compare_val("mem_addr", 0, 8'(mem_addr), 8'(e_maddr[0]));
			compare_val("mem_wdata", 0, mem_wdata, e_mwd[0]);
		end
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			compare_val("ret_vld", k, 8'(ret_vld[k]), 8'(e_vld[0][k]));
			compare_val("ret_wen", k, 8'(ret_wen[k]), 8'(e_wen[0][k]));
			// des and data only mean something on a write
			if (e_wen[0][k])
			begin
				compare_val("ret_des", k, 8'(ret_des[k]), 8'(e_des[0][k]));
				compare_val("ret_data", k, ret_data[k], e_data[0][k]);
			end
		end
		void'(e_edge.pop_front());
		void'(e_vld.pop_front());
		void'(e_wen.pop_front());
		void'(e_des.pop_front());
		void'(e_data.pop_front());
		void'(e_rej.pop_front());
		void'(e_mwe.pop_front());
		void'(e_maddr.pop_front());
		void'(e_mwd.pop_front());
		pending = e_edge.size();
	endtask

	// bundles sampled on the rising edge
	always @(posedge clk)
	begin
		if (rst)
			clear_state();
		else
		begin
			edge_cnt++;
			if (in_vld != '0)
				apply_bundle();
		end
	end

	// retire outputs settle two edges after sampling, read mid-cycle
	always @(negedge clk)
	begin
		if (edge_cnt > 0)
		begin
			if ((e_edge.size() > 0) && (e_edge[0] + 2 == edge_cnt))
				score_retire();
			else
				expect_quiet();
		end
	end

endmodule

// File: sim/tb_issue_cluster.sv
/* issue cluster testbench
   directed and random bundles on the falling edge, scoring in issue_checker */
`timescale 1ns/1ps

module tb_issue_cluster;

	localparam int NREGS = 16;
	localparam int MEM_WORDS = 16;
	// cycles allowed for the pipeline to empty
	localparam int DRAIN_LIMIT = 20;
	localparam int RANDOM_BUNDLES = 300;

	logic						clk;
	logic						rst;
	logic		[issue_pkg::lanes:1]		in_vld;
	issue_pkg::op_t		[issue_pkg::lanes:1]	in_op;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	in_des, in_s1, in_s2;
	issue_pkg::imm_t	[issue_pkg::lanes:1]	in_ime;

	logic		[issue_pkg::lanes:1]		ret_vld, ret_wen;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	ret_des;
	issue_pkg::data_t	[issue_pkg::lanes:1]	ret_data;
	logic						ret_reject;
	logic						mem_we;
	logic		[$clog2(MEM_WORDS)-1:0]		mem_addr;
	issue_pkg::data_t				mem_wdata;

	int	pending, errors, checks;

	// staged bundle, goes out on the next falling edge
	logic		[issue_pkg::lanes:1]		b_vld;
	issue_pkg::op_t		[issue_pkg::lanes:1]	b_op;
	issue_pkg::reg_idx_t	[issue_pkg::lanes:1]	b_des, b_s1, b_s2;
	issue_pkg::imm_t	[issue_pkg::lanes:1]	b_ime;

	int		n_tests, n_failed, err_mark;
	logic		timed_out;
	logic	[31:0]	rng;

	always #10 clk = ~clk;

	issue_cluster #(.NREGS(NREGS), .MEM_WORDS(MEM_WORDS)) UUT (
		.clk(clk), .rst(rst),
		.in_vld(in_vld), .in_op(in_op), .in_des(in_des),
		.in_s1(in_s1), .in_s2(in_s2), .in_ime(in_ime),
		.ret_vld(ret_vld), .ret_wen(ret_wen), .ret_des(ret_des),
		.ret_data(ret_data), .ret_reject(ret_reject),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	issue_checker #(.NREGS(NREGS), .MEM_WORDS(MEM_WORDS)) u_chk (
		.clk(clk), .rst(rst),
		.in_vld(in_vld), .in_op(in_op), .in_des(in_des),
		.in_s1(in_s1), .in_s2(in_s2), .in_ime(in_ime),
		.ret_vld(ret_vld), .ret_wen(ret_wen), .ret_des(ret_des),
		.ret_data(ret_data), .ret_reject(ret_reject),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.pending(pending), .errors(errors), .checks(checks)
	);

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// lcg, upper half is the usable part
	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng >> 16;
	endfunction

	task automatic clear_bundle();
		b_vld = '0;
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			b_op[k] = issue_pkg::op_nop;
			b_des[k] = '0;
			b_s1[k] = '0;
			b_s2[k] = '0;
			b_ime[k] = '0;
		end
	endtask

	task automatic put_slot(input int k, input issue_pkg::op_t op,
		input int des, input int s1, input int s2, input int ime);
		b_vld[k] = 1'b1;
		b_op[k] = op;
		b_des[k] = issue_pkg::reg_idx_t'(des);
		b_s1[k] = issue_pkg::reg_idx_t'(s1);
		b_s2[k] = issue_pkg::reg_idx_t'(s2);
		b_ime[k] = issue_pkg::imm_t'(ime);
	endtask

	task automatic send();
		@(negedge clk);
		in_vld <= b_vld;
		in_op <= b_op;
		in_des <= b_des;
		in_s1 <= b_s1;
		in_s2 <= b_s2;
		in_ime <= b_ime;
		clear_bundle();
	endtask

	// about one slot in four carries a load or store
	task automatic random_bundle();
		logic	[31:0]	r;
		logic	[31:0]	f;
		logic	[31:0]	g;
		for (int k = 1; k <= issue_pkg::lanes; k++)
		begin
			r = next_rand();
			f = next_rand();
			g = next_rand();
			if (r[2:0] != 3'd0)
			begin
				if (r[4:3] == 2'd0)
					put_slot(k, issue_pkg::op_t'(r[5] ?
						issue_pkg::op_load : issue_pkg::op_store),
						f[3:0], f[7:4], f[11:8], g[4:0]);
				else
					put_slot(k, issue_pkg::op_t'(4'(r[9:6] % 9)),
						f[3:0], f[7:4], f[11:8], g[4:0]);
			end
		end
	endtask

	// idle inputs, wait for the checker queue to empty, one line per test
	task automatic drain_and_report(input string name);
		int	waited;
		waited = 0;
		send();
		@(posedge clk);
		while ((pending != 0) && (waited < DRAIN_LIMIT))
		begin
			@(posedge clk);
			waited++;
		end
		if (pending != 0)
		begin
			$display("timeout in %s, %0d bundles never retired", name, pending);
			timed_out = 1'b1;
		end
		n_tests++;
		if ((errors != err_mark) || (pending != 0))
		begin
			n_failed++;
			$display("test %0d %s: failed, %0d errors", n_tests, name, errors - err_mark);
		end
		else
			$display("test %0d %s: ok", n_tests, name);
		err_mark = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	// quiet outputs, then loads from untouched memory
	task automatic after_reset_idle();
		repeat (4) send();
		put_slot(4, issue_pkg::op_load, 3, 0, 0, 5);
		send();
		put_slot(2, issue_pkg::op_load, 4, 0, 0, 9);
		put_slot(1, issue_pkg::op_addi, 5, 3, 0, 1);
		send();
		drain_and_report("after_reset_idle");
	endtask

	// memory op in slots 1 to 3 moves to slot 4
	task automatic swap_to_slot4();
		put_slot(1, issue_pkg::op_addi, 1, 0, 0, 7);
		put_slot(2, issue_pkg::op_addi, 2, 0, 0, 12);
		put_slot(3, issue_pkg::op_addi, 3, 0, 0, 21);
		put_slot(4, issue_pkg::op_addi, 4, 0, 0, 30);
		send();
		put_slot(1, issue_pkg::op_store, 0, 1, 2, 2);
		put_slot(2, issue_pkg::op_add, 5, 1, 2, 0);
		put_slot(3, issue_pkg::op_or, 6, 3, 4, 0);
		put_slot(4, issue_pkg::op_sub, 7, 4, 1, 0);
		send();
		put_slot(1, issue_pkg::op_and, 8, 3, 4, 0);
		put_slot(2, issue_pkg::op_load, 9, 1, 0, 2);
		put_slot(3, issue_pkg::op_xor, 10, 2, 3, 0);
		put_slot(4, issue_pkg::op_addi, 11, 5, 0, 3);
		send();
		put_slot(1, issue_pkg::op_addi, 12, 0, 0, 1);
		put_slot(2, issue_pkg::op_sub, 13, 7, 5, 0);
		put_slot(3, issue_pkg::op_load, 14, 0, 0, 9);
		put_slot(4, issue_pkg::op_add, 15, 9, 14, 0);
		send();
		drain_and_report("swap_to_slot4");
	endtask

	// every opcode, back to back on the previous results
	task automatic alu_chain();
		put_slot(1, issue_pkg::op_addi, 9, 0, 0, 29);
		put_slot(2, issue_pkg::op_addi, 10, 0, 0, 3);
		send();
		put_slot(1, issue_pkg::op_add, 11, 9, 10, 0);
		put_slot(2, issue_pkg::op_sub, 12, 10, 9, 0);
		put_slot(3, issue_pkg::op_and, 13, 9, 4, 0);
		put_slot(4, issue_pkg::op_or, 14, 9, 3, 0);
		send();
		put_slot(1, issue_pkg::op_xor, 15, 11, 12, 0);
		put_slot(2, issue_pkg::op_shl, 1, 11, 10, 0);
		put_slot(3, issue_pkg::op_shr, 2, 9, 10, 0);
		put_slot(4, issue_pkg::op_add, 3, 15, 1, 0);
		send();
		put_slot(1, issue_pkg::op_nop, 4, 1, 2, 5);
		put_slot(2, issue_pkg::op_shl, 5, 12, 9, 0);
		put_slot(3, issue_pkg::op_shr, 6, 12, 2, 0);
		put_slot(4, issue_pkg::op_addi, 7, 13, 0, 31);
		send();
		drain_and_report("alu_chain");
	endtask

	task automatic store_then_load();
		put_slot(4, issue_pkg::op_store, 0, 3, 4, 1);
		put_slot(1, issue_pkg::op_addi, 8, 0, 0, 11);
		send();
		put_slot(1, issue_pkg::op_load, 5, 3, 0, 1);
		send();
		repeat (3) send();
		put_slot(4, issue_pkg::op_load, 6, 3, 0, 1);
		send();
		put_slot(2, issue_pkg::op_store, 0, 0, 8, 15);
		send();
		put_slot(4, issue_pkg::op_load, 7, 0, 0, 15);
		send();
		drain_and_report("store_then_load");
	endtask

	// two and three memory ops, then a plain bundle
	task automatic reject_multi_mem();
		put_slot(1, issue_pkg::op_load, 1, 0, 0, 0);
		put_slot(2, issue_pkg::op_add, 2, 3, 4, 0);
		put_slot(3, issue_pkg::op_store, 0, 1, 2, 4);
		send();
		put_slot(1, issue_pkg::op_store, 0, 2, 3, 6);
		put_slot(2, issue_pkg::op_load, 9, 0, 0, 15);
		put_slot(3, issue_pkg::op_load, 10, 1, 0, 2);
		put_slot(4, issue_pkg::op_xor, 11, 1, 2, 0);
		send();
		put_slot(1, issue_pkg::op_add, 12, 1, 2, 0);
		put_slot(4, issue_pkg::op_store, 0, 0, 2, 3);
		send();
		drain_and_report("reject_multi_mem");
	endtask

	// same destination in several slots, later reads confirm the winner
	task automatic dup_dest_priority();
		for (int k = 1; k <= issue_pkg::lanes; k++)
			put_slot(k, issue_pkg::op_addi, 5, 0, 0, k);
		send();
		put_slot(1, issue_pkg::op_load, 5, 0, 0, 15);
		put_slot(2, issue_pkg::op_addi, 5, 5, 0, 20);
		put_slot(4, issue_pkg::op_addi, 5, 0, 0, 17);
		send();
		put_slot(1, issue_pkg::op_add, 6, 5, 0, 0);
		put_slot(2, issue_pkg::op_addi, 5, 5, 0, 1);
		put_slot(3, issue_pkg::op_sub, 5, 0, 5, 0);
		send();
		// one idle bundle so the last read comes from the array
		send();
		put_slot(1, issue_pkg::op_or, 7, 5, 5, 0);
		send();
		drain_and_report("dup_dest_priority");
	endtask

	task automatic random_traffic();
		repeat (RANDOM_BUNDLES)
		begin
			random_bundle();
			send();
		end
		drain_and_report("random_traffic");
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		rng = 32'd30297;
		timed_out = 1'b0;
		n_tests = 0;
		n_failed = 0;
		err_mark = 0;
		clear_bundle();
		in_vld = b_vld;
		in_op = b_op;
		in_des = b_des;
		in_s1 = b_s1;
		in_s2 = b_s2;
		in_ime = b_ime;
		// two rising edges in reset
		repeat (2) @(negedge clk);
		rst <= 1'b0;
		after_reset_idle();
		if (!timed_out)
			swap_to_slot4();
		if (!timed_out)
			alu_chain();
		if (!timed_out)
			store_then_load();
		if (!timed_out)
			reject_multi_mem();
		if (!timed_out)
			dup_dest_priority();
		if (!timed_out)
			random_traffic();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			n_tests, n_failed, checks, errors);
		if (timed_out || (errors != 0) || (n_failed != 0) || (checks == 0))
			$display("SOME TESTS FAILED");
		else
			$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: files.f
verilog/issue_pkg.sv
verilog/bundle_sort.sv
verilog/ins_swap.sv
verilog/exec_lane.sv
verilog/reg_file.sv
verilog/retire_mem.sv
verilog/issue_cluster.sv
sim/issue_checker.sv
sim/tb_issue_cluster.sv
